// File: Makefile
# Verilator build, run and lint for the load-store pipeline

VERILATOR ?= verilator
TOP       ?= tb_lsp_core
RTL_TOP   ?= lsp_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Ihw
RTL_FILES ?= hw/lsp_pkg.sv hw/issue_control.sv hw/hazard_timers.sv hw/reg_file.sv \
             hw/execute_stage.sv hw/memory_stage.sv hw/lsp_core.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall -Ihw --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+hw
hw/lsp_pkg.sv
hw/issue_control.sv
hw/hazard_timers.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/lsp_core.sv
test/tb_lsp_core.sv

// File: hw/execute_stage.sv
// execute stage: execute register, alu and execute/memory register
`timescale 1ns/100ps

module execute_stage (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              accept,
    input  logic              use_imm,
    input  logic              dest_we,
    input  logic              is_load,
    input  logic              is_store,
    input  lsp_pkg::alu_op_t  alu_op,
    input  lsp_pkg::reg_idx_t rd,
    input  lsp_pkg::word_t    opa,
    input  lsp_pkg::word_t    opb,
    input  lsp_pkg::word_t    imm,
    input  lsp_pkg::word_t    store_data,
    output logic              mem_valid_we,
    output logic              mem_load,
    output logic              mem_store,
    output lsp_pkg::reg_idx_t mem_rd,
    output lsp_pkg::word_t    mem_result,
    output lsp_pkg::word_t    mem_store_data
);
    import lsp_pkg::*;

    logic     ex_dest_we;
    logic     ex_load;
    logic     ex_store;
    logic     ex_use_imm;
    alu_op_t  ex_alu_op;
    reg_idx_t ex_rd;
    word_t    ex_opa;
    word_t    ex_opb;
    word_t    ex_imm;
    word_t    ex_store_data;
    word_t    alu_b;
    word_t    alu_out;

    // control flags, a stall leaves a bubble
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ex_dest_we <= 1'b0;
            ex_load    <= 1'b0;
            ex_store   <= 1'b0;
        end else begin
            ex_dest_we <= accept && dest_we;
            ex_load    <= accept && is_load;
            ex_store   <= accept && is_store;
        end
    end

    // operands only matter when the flags say so
    always_ff @(posedge clock) begin
        if (accept) begin
            ex_use_imm    <= use_imm;
            ex_alu_op     <= alu_op;
            ex_rd         <= rd;
            ex_opa        <= opa;
            ex_opb        <= opb;
            ex_imm        <= imm;
            ex_store_data <= store_data;
        end
    end

    assign alu_b = ex_use_imm ? ex_imm : ex_opb;

    // all ops wrap at the word width
    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_out = ex_opa + alu_b;
            ALU_SUB: alu_out = ex_opa - alu_b;
            ALU_AND: alu_out = ex_opa & alu_b;
            ALU_OR:  alu_out = ex_opa | alu_b;
            ALU_XOR: alu_out = ex_opa ^ alu_b;
            default: alu_out = alu_b;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mem_valid_we <= 1'b0;
            mem_load     <= 1'b0;
            mem_store    <= 1'b0;
        end else begin
            mem_valid_we <= ex_dest_we;
            mem_load     <= ex_load;
            mem_store    <= ex_store;
        end
    end

    always_ff @(posedge clock) begin
        mem_rd         <= ex_rd;
        mem_result     <= alu_out;
        mem_store_data <= ex_store_data;
    end

endmodule

// File: hw/hazard_timers.sv
// hazard timers: per-register countdown of pending writes, flags raw hazards
`timescale 1ns/100ps
`include "lsp_macros.svh"

module hazard_timers (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              accept,
    input  logic              dest_we,
    input  lsp_pkg::reg_idx_t rd,
    input  lsp_pkg::reg_idx_t rs,
    input  lsp_pkg::reg_idx_t rt,
    input  logic              rs_used,
    input  logic              rt_used,
    input  logic              rd_used,
    output logic              hazard
);

    localparam int TIMER_W = $clog2(`LSP_WB_LATENCY + 1);

    logic [TIMER_W-1:0] timer [`LSP_REG_COUNT];

    // a fresh write reloads the full latency, others drain toward zero
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `LSP_REG_COUNT; i++) begin
                timer[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `LSP_REG_COUNT; i++) begin
                if (accept && dest_we && (int'(rd) == i)) begin
                    timer[i] <= TIMER_W'(`LSP_WB_LATENCY);
                end else if (timer[i] != '0) begin
                    timer[i] <= timer[i] - 1'b1;
                end
            end
        end
    end

    // rd counts as a source only for stores
    assign hazard = (rs_used && (timer[rs] != '0))
                 || (rt_used && (timer[rt] != '0))
                 || (rd_used && (timer[rd] != '0));

endmodule

// File: hw/issue_control.sv
// issue control: memory clear sweep, run mode and instruction decode
`timescale 1ns/100ps
`include "lsp_macros.svh"

module issue_control (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  lsp_pkg::word_t    issue_instr,
    input  logic              hazard,
    output logic              ready,
    output logic              accept,
    output lsp_pkg::alu_op_t  alu_op,
    output logic              use_imm,
    output lsp_pkg::word_t    imm,
    output logic              dest_we,
    output lsp_pkg::reg_idx_t rd,
    output lsp_pkg::reg_idx_t rs,
    output lsp_pkg::reg_idx_t rt,
    output logic              rs_used,
    output logic              rt_used,
    output logic              rd_used,
    output logic              is_load,
    output logic              is_store,
    output logic              clear_en,
    output lsp_pkg::mem_addr_t clear_addr
);
    import lsp_pkg::*;

    typedef enum logic {ST_CLEAR, ST_RUN} state_t;

    state_t  state;
    opcode_t opcode;
    word_t   imm4_sext;
    word_t   imm8_zext;

    // sweep one data word per cycle, then run
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= ST_CLEAR;
            clear_addr <= '0;
        end else if (state == ST_CLEAR) begin
            clear_addr <= clear_addr + 1'b1;
            if (clear_addr == mem_addr_t'(`LSP_MEM_DEPTH - 1)) begin
                state <= ST_RUN;
            end
        end
    end

    assign clear_en = (state == ST_CLEAR);
    assign ready    = (state == ST_RUN) && !hazard;
    assign accept   = ready && issue_valid;

    // instruction fields
    assign opcode    = opcode_t'(issue_instr[15:12]);
    assign rd        = issue_instr[11:8];
    assign rs        = issue_instr[7:4];
    assign rt        = issue_instr[3:0];
    assign imm4_sext = {{(`LSP_WORD_W - 4){issue_instr[3]}}, issue_instr[3:0]};
    assign imm8_zext = word_t'(issue_instr[7:0]);

    always_comb begin
        alu_op   = ALU_PASS_B;
        use_imm  = 1'b0;
        imm      = imm4_sext;
        dest_we  = 1'b0;
        rs_used  = 1'b0;
        rt_used  = 1'b0;
        rd_used  = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                dest_we = 1'b1;
                rs_used = 1'b1;
                rt_used = 1'b1;
                case (opcode)
                    OP_ADD:  alu_op = ALU_ADD;
                    OP_SUB:  alu_op = ALU_SUB;
                    OP_AND:  alu_op = ALU_AND;
                    OP_OR:   alu_op = ALU_OR;
                    default: alu_op = ALU_XOR;
                endcase
            end
            OP_LI: begin
                dest_we = 1'b1;
                use_imm = 1'b1;
                imm     = imm8_zext;
            end
            OP_ADDI, OP_LW: begin
                alu_op  = ALU_ADD;
                dest_we = 1'b1;
                use_imm = 1'b1;
                rs_used = 1'b1;
                is_load = (opcode == OP_LW);
            end
            OP_SW: begin
                // address from rs plus imm4, data from rd
                alu_op   = ALU_ADD;
                use_imm  = 1'b1;
                rs_used  = 1'b1;
                rd_used  = 1'b1;
                is_store = 1'b1;
            end
            default: begin
                // nop and unused codes
            end
        endcase
    end

endmodule

// File: hw/lsp_core.sv
// lsp core: four-stage load-store pipeline top level
`timescale 1ns/100ps

module lsp_core (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  lsp_pkg::word_t     issue_instr,
    output logic               ready,
    output logic               wb_valid,
    output lsp_pkg::reg_idx_t  wb_rd,
    output lsp_pkg::word_t     wb_data,
    output logic               st_valid,
    output lsp_pkg::mem_addr_t st_addr,
    output lsp_pkg::word_t     st_data
);
    import lsp_pkg::*;

    // decode outputs
    logic      hazard;
    logic      accept;
    alu_op_t   alu_op;
    logic      use_imm;
    word_t     imm;
    logic      dest_we;
    reg_idx_t  rd;
    reg_idx_t  rs;
    reg_idx_t  rt;
    logic      rs_used;
    logic      rt_used;
    logic      rd_used;
    logic      is_load;
    logic      is_store;
    logic      clear_en;
    mem_addr_t clear_addr;

    // register operands
    word_t     opa;
    word_t     opb;
    word_t     store_data;

    // execute/memory register
    logic      mem_valid_we;
    logic      mem_load;
    logic      mem_store;
    reg_idx_t  mem_rd;
    word_t     mem_result;
    word_t     mem_store_data;

    issue_control i_issue_control (
        .clock       (clock),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .hazard      (hazard),
        .ready       (ready),
        .accept      (accept),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .imm         (imm),
        .dest_we     (dest_we),
        .rd          (rd),
        .rs          (rs),
        .rt          (rt),
        .rs_used     (rs_used),
        .rt_used     (rt_used),
        .rd_used     (rd_used),
        .is_load     (is_load),
        .is_store    (is_store),
        .clear_en    (clear_en),
        .clear_addr  (clear_addr)
    );

    hazard_timers i_hazard_timers (
        .clock   (clock),
        .rst_n   (rst_n),
        .accept  (accept),
        .dest_we (dest_we),
        .rd      (rd),
        .rs      (rs),
        .rt      (rt),
        .rs_used (rs_used),
        .rt_used (rt_used),
        .rd_used (rd_used),
        .hazard  (hazard)
    );

    // writeback register drives the write port
    reg_file i_reg_file (
        .clock   (clock),
        .rst_n   (rst_n),
        .we      (wb_valid),
        .waddr   (wb_rd),
        .wdata   (wb_data),
        .raddr_a (rs),
        .raddr_b (rt),
        .raddr_c (rd),
        .rdata_a (opa),
        .rdata_b (opb),
        .rdata_c (store_data)
    );

    execute_stage i_execute_stage (
        .clock          (clock),
        .rst_n          (rst_n),
        .accept         (accept),
        .use_imm        (use_imm),
        .dest_we        (dest_we),
        .is_load        (is_load),
        .is_store       (is_store),
        .alu_op         (alu_op),
        .rd             (rd),
        .opa            (opa),
        .opb            (opb),
        .imm            (imm),
        .store_data     (store_data),
        .mem_valid_we   (mem_valid_we),
        .mem_load       (mem_load),
        .mem_store      (mem_store),
        .mem_rd         (mem_rd),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data)
    );

    memory_stage i_memory_stage (
        .clock          (clock),
        .rst_n          (rst_n),
        .clear_en       (clear_en),
        .clear_addr     (clear_addr),
        .mem_valid_we   (mem_valid_we),
        .mem_load       (mem_load),
        .mem_store      (mem_store),
        .mem_rd         (mem_rd),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .st_valid       (st_valid),
        .st_addr        (st_addr),
        .st_data        (st_data)
    );

endmodule

// File: hw/lsp_macros.svh
// lsp macros: widths, depths and writeback latency of the load-store pipeline
`ifndef LSP_MACROS_SVH
`define LSP_MACROS_SVH

// data and instruction word width
`define LSP_WORD_W 16

// architectural registers
`define LSP_REG_COUNT 16

// data memory words
`define LSP_MEM_DEPTH 256

// edges from issue to register file write
`define LSP_WB_LATENCY 3

`endif

// File: hw/lsp_pkg.sv
// lsp package: shared word, index, address, opcode and alu types
`include "lsp_macros.svh"

package lsp_pkg;

    typedef logic [`LSP_WORD_W-1:0] word_t;

    typedef logic [$clog2(`LSP_REG_COUNT)-1:0] reg_idx_t;

    typedef logic [$clog2(`LSP_MEM_DEPTH)-1:0] mem_addr_t;

    // codes 10 to 15 are unnamed and behave as nop
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_LI   = 4'd6,
        OP_ADDI = 4'd7,
        OP_LW   = 4'd8,
        OP_SW   = 4'd9
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_PASS_B = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_AND    = 3'd3,
        ALU_OR     = 3'd4,
        ALU_XOR    = 3'd5
    } alu_op_t;

endpackage

// File: hw/memory_stage.sv
// memory stage: data memory with clear sweep, stores, loads and writeback register
`timescale 1ns/100ps
`include "lsp_macros.svh"

module memory_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               clear_en,
    input  lsp_pkg::mem_addr_t clear_addr,
    input  logic               mem_valid_we,
    input  logic               mem_load,
    input  logic               mem_store,
    input  lsp_pkg::reg_idx_t  mem_rd,
    input  lsp_pkg::word_t     mem_result,
    input  lsp_pkg::word_t     mem_store_data,
    output logic               wb_valid,
    output lsp_pkg::reg_idx_t  wb_rd,
    output lsp_pkg::word_t     wb_data,
    output logic               st_valid,
    output lsp_pkg::mem_addr_t st_addr,
    output lsp_pkg::word_t     st_data
);
    import lsp_pkg::*;

    word_t     data_mem [`LSP_MEM_DEPTH];
    mem_addr_t addr;
    word_t     load_data;

    // effective address wraps to the low bits
    assign addr      = mem_addr_t'(mem_result);
    assign load_data = data_mem[addr];

    // the sweep owns the array until run mode
    always_ff @(posedge clock) begin
        if (clear_en) begin
            data_mem[clear_addr] <= '0;
        end else if (mem_store) begin
            data_mem[addr] <= mem_store_data;
        end
    end

    assign st_valid = mem_store;
    assign st_addr  = addr;
    assign st_data  = mem_store_data;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid_we;
        end
    end

    always_ff @(posedge clock) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_load ? load_data : mem_result;
    end

endmodule

// File: hw/reg_file.sv
// register file: sixteen words, three combinational reads, one write
`timescale 1ns/100ps
`include "lsp_macros.svh"

module reg_file (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              we,
    input  lsp_pkg::reg_idx_t waddr,
    input  lsp_pkg::word_t    wdata,
    input  lsp_pkg::reg_idx_t raddr_a,
    input  lsp_pkg::reg_idx_t raddr_b,
    input  lsp_pkg::reg_idx_t raddr_c,
    output lsp_pkg::word_t    rdata_a,
    output lsp_pkg::word_t    rdata_b,
    output lsp_pkg::word_t    rdata_c
);
    import lsp_pkg::*;

    word_t regs [`LSP_REG_COUNT];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `LSP_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // rs, rt and store data
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign rdata_c = regs[raddr_c];

endmodule

// File: test/tb_lsp_core.sv
// lsp core testbench: random programs checked against an in-order architectural model
`timescale 1ns/100ps
`include "lsp_macros.svh"

module tb_lsp_core;
    import lsp_pkg::*;

    localparam logic [3:0] OPC_NOP  = 4'd0;
    localparam logic [3:0] OPC_ADD  = 4'd1;
    localparam logic [3:0] OPC_SUB  = 4'd2;
    localparam logic [3:0] OPC_AND  = 4'd3;
    localparam logic [3:0] OPC_OR   = 4'd4;
    localparam logic [3:0] OPC_XOR  = 4'd5;
    localparam logic [3:0] OPC_LI   = 4'd6;
    localparam logic [3:0] OPC_ADDI = 4'd7;
    localparam logic [3:0] OPC_LW   = 4'd8;
    localparam logic [3:0] OPC_SW   = 4'd9;

    // one stimulus mode per test
    localparam int T_ZERO  = 0;
    localparam int T_IMM   = 1;
    localparam int T_ALU   = 2;
    localparam int T_MEM   = 3;
    localparam int T_CHAIN = 4;
    localparam int T_NOP   = 5;

    localparam int N_ZERO  = 30;
    localparam int N_IMM   = 40;
    localparam int N_ALU   = 80;
    localparam int N_MEM   = 120;
    localparam int N_CHAIN = 60;
    localparam int N_NOP   = 40;
    localparam int N_TOTAL = N_ZERO + N_IMM + N_ALU + N_MEM + N_CHAIN + N_NOP;

    // clear sweep plus four cycles per instruction plus slack for drains
    localparam int TIMEOUT_CYCLES = 256 + 4 * N_TOTAL + 100;
    localparam int DRAIN_LIMIT    = 16;

    logic      clock       = 1'b0;
    logic      rst_n       = 1'b0;
    logic      issue_valid = 1'b0;
    word_t     issue_instr = '0;
    logic      ready;
    logic      wb_valid;
    reg_idx_t  wb_rd;
    word_t     wb_data;
    logic      st_valid;
    mem_addr_t st_addr;
    word_t     st_data;

    integer    seed         = 32'h5a00e577;
    int        check_errors = 0;
    int        other_errors = 0;
    int        checks       = 0;
    int        stalls       = 0;
    int        cycle_count  = 0;
    logic      accept_seen  = 1'b0;
    reg_idx_t  last_rd      = '0;

    word_t     model_regs [`LSP_REG_COUNT];
    word_t     model_mem [`LSP_MEM_DEPTH];
    reg_idx_t  exp_wb_rd [$];
    word_t     exp_wb_data [$];
    mem_addr_t exp_st_addr [$];
    word_t     exp_st_data [$];

    lsp_core i_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .ready       (ready),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .st_valid    (st_valid),
        .st_addr     (st_addr),
        .st_data     (st_data)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the core stopped making progress", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_wb(input reg_idx_t rd, input word_t data);
        reg_idx_t exp_rd;
        word_t    exp_data;
        if (exp_wb_rd.size() == 0) begin
            $display("writeback to r%0d at %0t with no write expected", rd, $time);
            check_errors++;
        end else begin
            exp_rd   = exp_wb_rd.pop_front();
            exp_data = exp_wb_data.pop_front();
            checks++;
            if (rd !== exp_rd || data !== exp_data) begin
                $display("[FAIL] %0t: writeback r%0d = %h, expected r%0d = %h",
                         $time, rd, data, exp_rd, exp_data);
                check_errors++;
            end
        end
    endtask

    task automatic check_store(input mem_addr_t addr, input word_t data);
        mem_addr_t exp_addr;
        word_t     exp_data;
        if (exp_st_addr.size() == 0) begin
            $display("store to %h at %0t with no store expected", addr, $time);
            check_errors++;
        end else begin
            exp_addr = exp_st_addr.pop_front();
            exp_data = exp_st_data.pop_front();
            checks++;
            if (addr !== exp_addr || data !== exp_data) begin
                $display("[FAIL] %0t: store [%h] = %h, expected [%h] = %h",
                         $time, addr, data, exp_addr, exp_data);
                check_errors++;
            end
        end
    endtask

    // outputs settle mid-cycle
    always @(negedge clock) begin
        accept_seen = issue_valid && ready;
        if (issue_valid && !ready) begin
            stalls++;
        end
        if (wb_valid) begin
            check_wb(wb_rd, wb_data);
        end
        if (st_valid) begin
            check_store(st_addr, st_data);
        end
    end

    task automatic model_write(input reg_idx_t rd, input word_t value);
        model_regs[rd] = value;
        exp_wb_rd.push_back(rd);
        exp_wb_data.push_back(value);
    endtask

    // architectural effect of one accepted instruction
    task automatic model_execute(input word_t instr);
        reg_idx_t  rd;
        reg_idx_t  rs;
        reg_idx_t  rt;
        word_t     a;
        word_t     b;
        word_t     imm4;
        mem_addr_t addr;
        rd   = instr[11:8];
        rs   = instr[7:4];
        rt   = instr[3:0];
        a    = model_regs[rs];
        b    = model_regs[rt];
        imm4 = {{12{instr[3]}}, instr[3:0]};
        addr = mem_addr_t'(a + imm4);
        case (instr[15:12])
            OPC_ADD:  model_write(rd, a + b);
            OPC_SUB:  model_write(rd, a - b);
            OPC_AND:  model_write(rd, a & b);
            OPC_OR:   model_write(rd, a | b);
            OPC_XOR:  model_write(rd, a ^ b);
            OPC_LI:   model_write(rd, {8'h00, instr[7:0]});
            OPC_ADDI: model_write(rd, a + imm4);
            OPC_LW:   model_write(rd, model_mem[addr]);
            OPC_SW: begin
                model_mem[addr] = model_regs[rd];
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(model_regs[rd]);
            end
            default: begin
                // nop and unused codes
            end
        endcase
    endtask

    function automatic word_t make_instr(input int mode);
        logic [31:0] r;
        logic [3:0]  op;
        reg_idx_t    rd;
        reg_idx_t    rs;
        logic [3:0]  rt_imm;
        r      = $random(seed);
        op     = OPC_NOP;
        rd     = r[11:8];
        rs     = r[7:4];
        rt_imm = r[3:0];
        case (mode)
            T_ZERO: begin
                // bases in r12..r15 spread the loads over the whole memory
                if (r[18:17] == 2'd0) begin
                    op = OPC_LI;
                    rd = {2'b11, r[9:8]};
                end else begin
                    op = r[16] ? OPC_LW : OPC_ADD;
                    rd = 4'(r[11:8] % 12);
                    if (op == OPC_LW) begin
                        rs = {2'b11, r[5:4]};
                    end else begin
                        // r0..r11 hold only zeros in this test
                        rs     = 4'(r[7:4] % 12);
                        rt_imm = 4'(r[3:0] % 12);
                    end
                end
            end
            T_IMM:  op = r[16] ? OPC_LI : OPC_ADDI;
            T_ALU:  op = (r[18:16] == 3'd0) ? OPC_LI : 4'(1 + r[23:20] % 5);
            T_MEM: begin
                // bases stay in r0..r3 so addresses repeat often
                if (r[18:16] == 3'd0) begin
                    op = OPC_LI;
                    rd = {2'b00, r[9:8]};
                end else begin
                    op = (r[18:16] < 3'd5) ? OPC_SW : OPC_LW;
                    rs = {2'b00, r[5:4]};
                    if (op == OPC_LW) begin
                        rd = 4'(4 + r[11:8] % 12);
                    end
                end
            end
            T_CHAIN: begin
                rs = last_rd;
                case (r[18:16])
                    3'd5:    op = OPC_ADDI;
                    3'd6:    op = OPC_LW;
                    3'd7:    op = OPC_SW;
                    default: op = 4'(1 + r[18:16]);
                endcase
                last_rd = rd;
            end
            T_NOP:   op = r[16] ? OPC_NOP : 4'(10 + r[19:17] % 6);
            default: op = OPC_NOP;
        endcase
        return {op, rd, rs, rt_imm};
    endfunction

    task automatic run_test(input string name, input int mode, input int count);
        int    issued;
        int    err0;
        int    stall0;
        int    wait_cycles;
        word_t instr;
        issued = 0;
        err0   = check_errors + other_errors;
        stall0 = stalls;
        instr  = '0;
        while (issued < count) begin
            @(posedge clock);
            if (accept_seen) begin
                model_execute(instr);
                issued++;
            end
            // a refused instruction stays on the port
            if (accept_seen || !issue_valid) begin
                if (issued < count && ($random(seed) & 3) != 0) begin
                    instr = make_instr(mode);
                    issue_valid <= 1'b1;
                    issue_instr <= instr;
                end else begin
                    issue_valid <= 1'b0;
                end
            end
        end
        wait_cycles = 0;
        while ((exp_wb_rd.size() != 0 || exp_st_addr.size() != 0)
               && wait_cycles < DRAIN_LIMIT) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (exp_wb_rd.size() != 0 || exp_st_addr.size() != 0) begin
            $display("%0d writebacks and %0d stores never appeared in test %s",
                     exp_wb_rd.size(), exp_st_addr.size(), name);
            other_errors++;
            exp_wb_rd.delete();
            exp_wb_data.delete();
            exp_st_addr.delete();
            exp_st_data.delete();
        end
        // room for stray outputs
        repeat (4) @(posedge clock);
        if (mode == T_CHAIN && stalls == stall0) begin
            $display("ready never dropped during the dependent chain");
            other_errors++;
        end
        $display("test %s: %0d instructions, %0d stall cycles, %0d errors",
                 name, count, stalls - stall0, check_errors + other_errors - err0);
    endtask

    initial begin
        int sweep_cycles;
        for (int i = 0; i < `LSP_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `LSP_MEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;

        // ready stays low for the whole clear sweep
        sweep_cycles = 0;
        @(negedge clock);
        while (!ready) begin
            sweep_cycles++;
            @(negedge clock);
        end
        if (sweep_cycles != `LSP_MEM_DEPTH) begin
            $display("[FAIL] %0t: clear sweep took %0d cycles, expected %0d",
                     $time, sweep_cycles, `LSP_MEM_DEPTH);
            other_errors++;
        end
        $display("test sweep: %0d cycles before ready", sweep_cycles);

        run_test("zero_reads", T_ZERO, N_ZERO);
        run_test("immediates", T_IMM, N_IMM);
        run_test("alu_ops", T_ALU, N_ALU);
        run_test("load_store", T_MEM, N_MEM);
        run_test("dep_chain", T_CHAIN, N_CHAIN);
        run_test("no_effect", T_NOP, N_NOP);

        $display("checks %0d, errors %0d", checks, check_errors + other_errors);
        if (check_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
